// ==== design/core_defines.svh ====
// Core widths and MIPS opcode and funct encodings shared by RTL and testbench
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ====================
// widths
// ====================

// data path and address width
`define CORE_XLEN 32

// register index width, 32 architectural registers
`define CORE_REG_AW 5

// data memory word address width
`define CORE_DMEM_AW 7

// shift amount field of R-type
`define CORE_SHAMT_W 5

// jump index field of J-type
`define CORE_JIDX_W 26

// return address register written by jal
`define CORE_REG_RA 5'd31

// ====================
// opcodes, instr[31:26]
// ====================

// all register-type ops share opcode zero
`define CORE_OP_RTYPE 6'h00
`define CORE_OP_J 6'h02
`define CORE_OP_JAL 6'h03
`define CORE_OP_BEQ 6'h04

// memory ops
`define CORE_OP_LW 6'h23
`define CORE_OP_SW 6'h2b

// ====================
// funct codes, instr[5:0]
// ====================

// shifts by the shamt field
`define CORE_FN_SLL 6'h00
`define CORE_FN_SRL 6'h02

// register jump
`define CORE_FN_JR 6'h08

// arithmetic and logic
`define CORE_FN_ADD 6'h20
`define CORE_FN_SUB 6'h22
`define CORE_FN_AND 6'h24
`define CORE_FN_OR 6'h25

// signed compare
`define CORE_FN_SLT 6'h2a

`endif

// ==== design/mipsPkg.sv ====
// Shared types of the single-cycle MIPS core and its decoded control word
`default_nettype none

`include "core_defines.svh"

package mipsPkg;

  // ====================
  // plain vector types
  // ====================

  // one data word or byte address
  typedef logic [`CORE_XLEN-1:0] word_t;

  // register file index
  typedef logic [`CORE_REG_AW-1:0] regAddr_t;

  // data memory address as seen on the port
  typedef logic [`CORE_DMEM_AW-1:0] dmemAddr_t;

  // ====================
  // enums
  // ====================

  // operations the execute stage can perform
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } aluOp_t;

  // where the next pc comes from
  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JUMP,
    PC_REG
  } pcSel_t;

  // destination register field choice
  typedef enum logic [1:0] {
    DST_RT,
    DST_RD,
    DST_RA
  } dstSel_t;

  // decoded control, one per instruction
  typedef struct packed {
    logic    regWrite;
    dstSel_t regDst;
    logic    aluSrcImm;
    logic    shiftImm;
    logic    memWrite;
    logic    memToReg;
    logic    link;
    logic    branch;
    logic    jump;
    logic    jumpReg;
    aluOp_t  aluOp;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== design/instFetch.sv ====
// Instruction fetch: pc register and next-pc choice among sequential, branch and jumps
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module instFetch (
  input  wire                          clk,
  input  wire                          rst,
  input  wire mipsPkg::ctrl_t          ctrl,
  input  wire                          aluZero,
  input  wire mipsPkg::word_t          immExt,
  input  wire [`CORE_JIDX_W-1:0]       jumpIndex,
  input  wire mipsPkg::word_t          rsData,
  output mipsPkg::word_t               pc,
  output mipsPkg::word_t               linkAddr
);

  mipsPkg::word_t pcPlus4;
  mipsPkg::word_t branchTarget;
  mipsPkg::word_t jumpTarget;
  mipsPkg::word_t nextPc;
  mipsPkg::pcSel_t pcSel;

  // ====================
  // target arithmetic
  // ====================

  assign pcPlus4 = pc + `CORE_XLEN'd4;

  // jal return point, skips the slot after the jump
  assign linkAddr = pc + `CORE_XLEN'd8;

  // word offset scaled to bytes
  assign branchTarget = pcPlus4 + {immExt[`CORE_XLEN-3:0], 2'b00};

  // upper four bits kept from pc+4
  assign jumpTarget = {pcPlus4[`CORE_XLEN-1:`CORE_XLEN-4], jumpIndex, 2'b00};

  // ====================
  // next pc
  // ====================

  // decode never raises two flow bits at once, so order is only a tie-break
  always_comb begin
    if (ctrl.jumpReg) begin
      pcSel = mipsPkg::PC_REG;
    end else if (ctrl.jump) begin
      pcSel = mipsPkg::PC_JUMP;
    end else if (ctrl.branch && aluZero) begin
      pcSel = mipsPkg::PC_BRANCH;
    end else begin
      pcSel = mipsPkg::PC_SEQ;
    end
  end

  always_comb begin
    case (pcSel)
      mipsPkg::PC_BRANCH: nextPc = branchTarget;
      mipsPkg::PC_JUMP:   nextPc = jumpTarget;
      mipsPkg::PC_REG:    nextPc = rsData;
      default:            nextPc = pcPlus4;
    endcase
  end

  // only state in the fetch path
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // jr takes whatever the register holds, so alignment is a program property
  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== design/instDecode.sv ====
// Instruction decode: main control, ALU control, register fields and immediate
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module instDecode (
  input  wire mipsPkg::word_t         instr,
  output mipsPkg::ctrl_t              ctrl,
  output mipsPkg::regAddr_t           rsAddr,
  output mipsPkg::regAddr_t           rtAddr,
  output mipsPkg::regAddr_t           destAddr,
  output mipsPkg::word_t              immExt,
  output logic [`CORE_SHAMT_W-1:0]    shamt
);

  // first level result, like the classic two-bit ALUOp
  typedef enum logic [1:0] {
    CLS_ADD,
    CLS_SUB,
    CLS_FUNCT
  } aluClass_t;

  logic [5:0] opcode;
  logic [5:0] funct;
  aluClass_t aluClass;
  mipsPkg::ctrl_t mainCtrl;
  mipsPkg::aluOp_t aluOp;
  logic functOk;
  logic isShift;
  logic isJr;

  assign opcode = instr[31:26];
  assign funct = instr[5:0];

  // ====================
  // instruction fields
  // ====================

  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];
  assign shamt = instr[10:6];
  assign immExt = {{(`CORE_XLEN-16){instr[15]}}, instr[15:0]};

  // ====================
  // main control
  // ====================

  always_comb begin
    mainCtrl = '0;
    mainCtrl.regDst = mipsPkg::DST_RT;
    aluClass = CLS_ADD;
    case (opcode)
      `CORE_OP_RTYPE: begin
        mainCtrl.regWrite = 1'b1;
        mainCtrl.regDst = mipsPkg::DST_RD;
        aluClass = CLS_FUNCT;
      end
      `CORE_OP_LW: begin
        mainCtrl.regWrite = 1'b1;
        mainCtrl.aluSrcImm = 1'b1;
        mainCtrl.memToReg = 1'b1;
      end
      `CORE_OP_SW: begin
        mainCtrl.aluSrcImm = 1'b1;
        mainCtrl.memWrite = 1'b1;
      end
      `CORE_OP_BEQ: begin
        // compare by subtraction, zero flag decides
        mainCtrl.branch = 1'b1;
        aluClass = CLS_SUB;
      end
      `CORE_OP_J: begin
        mainCtrl.jump = 1'b1;
      end
      `CORE_OP_JAL: begin
        mainCtrl.jump = 1'b1;
        mainCtrl.link = 1'b1;
        mainCtrl.regWrite = 1'b1;
        mainCtrl.regDst = mipsPkg::DST_RA;
      end
      default: begin
        // unknown opcode, no side effects
        aluClass = CLS_ADD;
      end
    endcase
  end

  // ====================
  // ALU control
  // ====================

  always_comb begin
    aluOp = mipsPkg::ALU_ADD;
    functOk = 1'b1;
    isShift = 1'b0;
    isJr = 1'b0;
    case (aluClass)
      CLS_SUB: aluOp = mipsPkg::ALU_SUB;
      CLS_FUNCT: begin
        case (funct)
          `CORE_FN_ADD: aluOp = mipsPkg::ALU_ADD;
          `CORE_FN_SUB: aluOp = mipsPkg::ALU_SUB;
          `CORE_FN_AND: aluOp = mipsPkg::ALU_AND;
          `CORE_FN_OR:  aluOp = mipsPkg::ALU_OR;
          `CORE_FN_SLT: aluOp = mipsPkg::ALU_SLT;
          `CORE_FN_SLL: begin
            aluOp = mipsPkg::ALU_SLL;
            isShift = 1'b1;
          end
          `CORE_FN_SRL: begin
            aluOp = mipsPkg::ALU_SRL;
            isShift = 1'b1;
          end
          `CORE_FN_JR: isJr = 1'b1;
          default:     functOk = 1'b0;
        endcase
      end
      default: aluOp = mipsPkg::ALU_ADD;
    endcase
  end

  // merge both levels, jr and bad funct never write back
  always_comb begin
    ctrl = mainCtrl;
    ctrl.aluOp = aluOp;
    ctrl.shiftImm = isShift;
    ctrl.jumpReg = isJr;
    if (isJr || !functOk) begin
      ctrl.regWrite = 1'b0;
    end
  end

  // destination register select
  always_comb begin
    case (ctrl.regDst)
      mipsPkg::DST_RD: destAddr = instr[15:11];
      mipsPkg::DST_RA: destAddr = `CORE_REG_RA;
      default:         destAddr = instr[20:16];
    endcase
  end

  // fetch relies on at most one flow change per instruction
  always_comb begin
    oneFlow: assert final ($onehot0({ctrl.jump, ctrl.jumpReg, ctrl.branch}))
      else $error("conflicting flow control for instr %h", instr);
  end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
// Register file: 32 words, two combinational read ports, one clocked write port
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module regFile (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     we,
  input  wire mipsPkg::regAddr_t  rdAddrA,
  input  wire mipsPkg::regAddr_t  rdAddrB,
  input  wire mipsPkg::regAddr_t  wrAddr,
  input  wire mipsPkg::word_t     wrData,
  output mipsPkg::word_t          rdDataA,
  output mipsPkg::word_t          rdDataB
);

  localparam int numRegs = 1 << `CORE_REG_AW;

  mipsPkg::word_t regs [numRegs];

  // ====================
  // write port
  // ====================

  // whole file cleared while rst is low
  // $zero is never written so it stays at reset value
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ====================
  // read ports
  // ====================

  // index zero forced, independent of storage contents
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== design/execUnit.sv ====
// Execute stage: operand muxing, ALU with shifter, and zero flag for beq
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execUnit (
  input  wire mipsPkg::ctrl_t          ctrl,
  input  wire mipsPkg::word_t          rsData,
  input  wire mipsPkg::word_t          rtData,
  input  wire mipsPkg::word_t          immExt,
  input  wire [`CORE_SHAMT_W-1:0]      shamt,
  output mipsPkg::word_t               result,
  output logic                         zero
);

  mipsPkg::word_t opA;
  mipsPkg::word_t opB;

  // ====================
  // operands
  // ====================

  // shifts work on rt, everything else on rs
  assign opA = ctrl.shiftImm ? rtData : rsData;

  // immediate for lw/sw address calculation
  assign opB = ctrl.aluSrcImm ? immExt : rtData;

  // ====================
  // ALU
  // ====================

  always_comb begin
    case (ctrl.aluOp)
      mipsPkg::ALU_ADD: result = opA + opB;
      mipsPkg::ALU_SUB: result = opA - opB;
      mipsPkg::ALU_AND: result = opA & opB;
      mipsPkg::ALU_OR:  result = opA | opB;
      mipsPkg::ALU_SLT: begin
        // signed compare, 1 or 0
        result = ($signed(opA) < $signed(opB)) ? `CORE_XLEN'd1 : `CORE_XLEN'd0;
      end
      mipsPkg::ALU_SLL: result = opA << shamt;
      mipsPkg::ALU_SRL: result = opA >> shamt;
      default:          result = '0;
    endcase
  end

  // equality test for beq only
  assign zero = (ctrl.aluOp == mipsPkg::ALU_SUB) && (result == '0);

  // an X here means decode saw an undriven instruction word
  always_comb begin
    aluOpKnown: assert final (!$isunknown(ctrl.aluOp))
      else $error("aluOp unknown");
  end

endmodule

`default_nettype wire

// ==== design/singleCycleMips.sv ====
// Single-cycle MIPS core top: joins fetch, decode, registers, execute and write-back
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module singleCycleMips (
  input  wire                        clk,
  input  wire                        rst,
  // instruction memory, combinational read
  output mipsPkg::word_t             instAddr,
  input  wire mipsPkg::word_t        instr,
  // data memory, write is active low
  output mipsPkg::dmemAddr_t         dmemAddr,
  output mipsPkg::word_t             dmemWdata,
  output logic                       dmemWen,
  input  wire mipsPkg::word_t        dmemRdata,
  // register write observation
  output logic                       wbEn,
  output mipsPkg::regAddr_t          wbAddr,
  output mipsPkg::word_t             wbData
);

  mipsPkg::ctrl_t decodeCtrl;
  mipsPkg::regAddr_t rsAddr;
  mipsPkg::regAddr_t rtAddr;
  mipsPkg::regAddr_t destAddr;
  mipsPkg::word_t immExt;
  logic [`CORE_SHAMT_W-1:0] shamt;
  mipsPkg::word_t rsData;
  mipsPkg::word_t rtData;
  mipsPkg::word_t aluResult;
  logic aluZero;
  mipsPkg::word_t linkAddr;

  // ====================
  // stages
  // ====================

  instFetch fetch_i (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (decodeCtrl),
    .aluZero   (aluZero),
    .immExt    (immExt),
    .jumpIndex (instr[`CORE_JIDX_W-1:0]),
    .rsData    (rsData),
    .pc        (instAddr),
    .linkAddr  (linkAddr)
  );

  instDecode decode_i (
    .instr    (instr),
    .ctrl     (decodeCtrl),
    .rsAddr   (rsAddr),
    .rtAddr   (rtAddr),
    .destAddr (destAddr),
    .immExt   (immExt),
    .shamt    (shamt)
  );

  regFile regs_i (
    .clk     (clk),
    .rst     (rst),
    .we      (decodeCtrl.regWrite),
    .rdAddrA (rsAddr),
    .rdAddrB (rtAddr),
    .wrAddr  (destAddr),
    .wrData  (wbData),
    .rdDataA (rsData),
    .rdDataB (rtData)
  );

  execUnit exec_i (
    .ctrl   (decodeCtrl),
    .rsData (rsData),
    .rtData (rtData),
    .immExt (immExt),
    .shamt  (shamt),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ====================
  // write-back and memory
  // ====================

  // link beats load beats ALU
  always_comb begin
    if (decodeCtrl.link) begin
      wbData = linkAddr;
    end else if (decodeCtrl.memToReg) begin
      wbData = dmemRdata;
    end else begin
      wbData = aluResult;
    end
  end

  assign wbEn = decodeCtrl.regWrite;
  assign wbAddr = destAddr;

  // low address bits go straight to the memory
  assign dmemAddr = aluResult[`CORE_DMEM_AW-1:0];
  assign dmemWdata = rtData;
  assign dmemWen = ~decodeCtrl.memWrite;

  // a store and a register write never commit on the same edge
  storeNoWb: assert property (@(posedge clk) disable iff (!rst) !dmemWen |-> !wbEn)
    else $error("store also writes register %0d", wbAddr);

endmodule

`default_nettype wire

// ==== tb/tbClock.sv ====
// Testbench clock and reset source for the core
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter real periodNs = 4.0,
  parameter int  resetCycles = 10
) (
  output logic clk,
  output logic rst
);

  // free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2.0) clk = ~clk;
  end

  // reset held for the requested rising edges, released on a falling edge
  initial begin
    rst = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/coreChecker.sv ====
// Checker comparing core write-back, stores and pc flow against the expected row
`timescale 1ns/1ps
`default_nettype none

module coreChecker (
  input  wire                      clk,
  input  wire                      rst,
  // observed core outputs
  input  wire mipsPkg::word_t      instAddr,
  input  wire                      dmemWen,
  input  wire mipsPkg::dmemAddr_t  dmemAddr,
  input  wire mipsPkg::word_t      dmemWdata,
  input  wire                      wbEn,
  input  wire mipsPkg::regAddr_t   wbAddr,
  input  wire mipsPkg::word_t      wbData,
  // expectation of the row at the current pc
  input  wire                      rowValid,
  input  wire mipsPkg::word_t      expNextPc,
  input  wire                      expWbEn,
  input  wire mipsPkg::regAddr_t   expWbAddr,
  input  wire mipsPkg::word_t      expWbData,
  input  wire                      expMemWen,
  input  wire mipsPkg::dmemAddr_t  expMemAddr,
  input  wire mipsPkg::word_t      expMemData,
  output int                       errorCount,
  output int                       checkCount
);

  int errors = 0;
  int checks = 0;
  // pc the previous instruction should have produced
  mipsPkg::word_t prevNextPc;

  assign errorCount = errors;
  assign checkCount = checks;

  task automatic compareField(input string name, input mipsPkg::word_t got,
                              input mipsPkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h, pc %h", name, got, exp, instAddr);
    end
  endtask

  // ====================
  // sampling
  // ====================

  // outputs are still those of the committing instruction at this edge
  always @(posedge clk) begin
    if (!rst) begin
      compareField("instAddr", instAddr, '0);
      compareField("dmemWen", dmemWen, 1);
      compareField("wbEn", wbEn, 0);
      prevNextPc <= '0;
    end else begin
      // flow check also covers the step past the last row
      compareField("instAddr", instAddr, prevNextPc);
      if (rowValid) begin
        compareField("wbEn", wbEn, expWbEn);
        if (expWbEn) begin
          compareField("wbAddr", wbAddr, expWbAddr);
          compareField("wbData", wbData, expWbData);
        end
        compareField("dmemWen", dmemWen, expMemWen);
        // address and data only matter on a store
        if (!expMemWen) begin
          compareField("dmemAddr", dmemAddr, expMemAddr);
          compareField("dmemWdata", dmemWdata, expMemData);
        end
        prevNextPc <= expNextPc;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tbTop.sv ====
// Testbench top: program table, memory models, stimulus loop and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tbTop;

  localparam int  numRows = 29;
  localparam real periodNs = 4.0;
  localparam real timeoutNs = (numRows + 20) * periodNs;
  // opcode 3f decodes to nothing, keeps the core quiet in reset
  localparam mipsPkg::word_t idleInstr = 32'hffff_ffff;

  // one program word and what its cycle must show
  typedef struct packed {
    mipsPkg::word_t     instr;
    mipsPkg::word_t     nextPc;
    logic               wbEn;
    mipsPkg::regAddr_t  wbAddr;
    mipsPkg::word_t     wbData;
    logic               memWen;
    mipsPkg::dmemAddr_t memAddr;
    mipsPkg::word_t     memData;
  } row_t;

  logic clk;
  logic rst;
  mipsPkg::word_t instAddr;
  mipsPkg::word_t instr;
  mipsPkg::dmemAddr_t dmemAddr;
  mipsPkg::word_t dmemWdata;
  logic dmemWen;
  mipsPkg::word_t dmemRdata;
  logic wbEn;
  mipsPkg::regAddr_t wbAddr;
  mipsPkg::word_t wbData;
  int errorCount;
  int checkCount;

  row_t progTable [numRows];
  row_t curRow;
  logic rowValid;
  mipsPkg::word_t dmem [1 << `CORE_DMEM_AW];

  tbClock #(.periodNs(periodNs), .resetCycles(10)) clock_i (.clk(clk), .rst(rst));

  singleCycleMips dut_i (
    .clk       (clk),
    .rst       (rst),
    .instAddr  (instAddr),
    .instr     (instr),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemWen   (dmemWen),
    .dmemRdata (dmemRdata),
    .wbEn      (wbEn),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  coreChecker check_i (
    .clk        (clk),
    .rst        (rst),
    .instAddr   (instAddr),
    .dmemWen    (dmemWen),
    .dmemAddr   (dmemAddr),
    .dmemWdata  (dmemWdata),
    .wbEn       (wbEn),
    .wbAddr     (wbAddr),
    .wbData     (wbData),
    .rowValid   (rowValid),
    .expNextPc  (curRow.nextPc),
    .expWbEn    (curRow.wbEn),
    .expWbAddr  (curRow.wbAddr),
    .expWbData  (curRow.wbData),
    .expMemWen  (curRow.memWen),
    .expMemAddr (curRow.memAddr),
    .expMemData (curRow.memData),
    .errorCount (errorCount),
    .checkCount (checkCount)
  );

  // ====================
  // memory models
  // ====================

  assign dmemRdata = dmem[dmemAddr];

  always @(posedge clk) begin
    if (rst && (dmemWen == 1'b0)) begin
      dmem[dmemAddr] <= dmemWdata;
    end
  end

  // row under the current pc, empty once the program ran off the end
  assign rowValid = (instAddr >> 2) < numRows;
  always_comb begin
    curRow = rowValid ? progTable[instAddr >> 2] : '0;
  end

  // ====================
  // encoders and table rows
  // ====================

  function automatic mipsPkg::word_t rType(mipsPkg::regAddr_t rs, mipsPkg::regAddr_t rt,
                                           mipsPkg::regAddr_t rd, logic [4:0] sh,
                                           logic [5:0] fn);
    return {`CORE_OP_RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic mipsPkg::word_t iType(logic [5:0] op, mipsPkg::regAddr_t rs,
                                           mipsPkg::regAddr_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic mipsPkg::word_t jType(logic [5:0] op, mipsPkg::word_t target);
    return {op, target[27:2]};
  endfunction

  task automatic writeRow(input int idx, input mipsPkg::word_t ins,
                          input mipsPkg::regAddr_t rd, input mipsPkg::word_t val);
    progTable[idx] = '0;
    progTable[idx].instr = ins;
    progTable[idx].nextPc = idx * 4 + 4;
    progTable[idx].wbEn = 1'b1;
    progTable[idx].wbAddr = rd;
    progTable[idx].wbData = val;
    progTable[idx].memWen = 1'b1;
  endtask

  task automatic storeRow(input int idx, input mipsPkg::word_t ins,
                          input mipsPkg::dmemAddr_t addr, input mipsPkg::word_t val);
    progTable[idx] = '0;
    progTable[idx].instr = ins;
    progTable[idx].nextPc = idx * 4 + 4;
    progTable[idx].memAddr = addr;
    progTable[idx].memData = val;
  endtask

  // branch or jump, nothing written
  task automatic flowRow(input int idx, input mipsPkg::word_t ins,
                         input mipsPkg::word_t target);
    progTable[idx] = '0;
    progTable[idx].instr = ins;
    progTable[idx].nextPc = target;
    progTable[idx].memWen = 1'b1;
  endtask

  // expectations follow the ISA rules on values loaded from dmem
  task automatic buildProgram;
    mipsPkg::word_t a;
    mipsPkg::word_t b;
    mipsPkg::word_t p;
    mipsPkg::word_t n;
    mipsPkg::word_t base;
    mipsPkg::word_t sltLo;
    mipsPkg::word_t sltHi;
    mipsPkg::word_t stAddr;
    a = dmem[5];
    b = dmem[9];
    // p has bit 31 clear, so n is negative unless p is zero
    p = a >> 1;
    n = 32'd0 - p;
    base = b >> 28;
    stAddr = base + 32'd3;
    // negative n sits below p, equal only when both are zero
    sltLo = (p != 32'd0) ? 32'd1 : 32'd0;
    // p is never below its own negation
    sltHi = 32'd0;
    writeRow(0, iType(`CORE_OP_LW, 5'd0, 5'd1, 16'd5), 5'd1, a);
    writeRow(1, iType(`CORE_OP_LW, 5'd0, 5'd2, 16'd9), 5'd2, b);
    writeRow(2, rType(5'd1, 5'd2, 5'd3, 5'd0, `CORE_FN_ADD), 5'd3, a + b);
    writeRow(3, rType(5'd1, 5'd2, 5'd4, 5'd0, `CORE_FN_SUB), 5'd4, a - b);
    writeRow(4, rType(5'd1, 5'd2, 5'd5, 5'd0, `CORE_FN_AND), 5'd5, a & b);
    writeRow(5, rType(5'd1, 5'd2, 5'd6, 5'd0, `CORE_FN_OR), 5'd6, a | b);
    writeRow(6, rType(5'd0, 5'd1, 5'd7, 5'd1, `CORE_FN_SRL), 5'd7, p);
    writeRow(7, rType(5'd0, 5'd7, 5'd8, 5'd0, `CORE_FN_SUB), 5'd8, n);
    writeRow(8, rType(5'd8, 5'd7, 5'd9, 5'd0, `CORE_FN_SLT), 5'd9, sltLo);
    writeRow(9, rType(5'd7, 5'd8, 5'd10, 5'd0, `CORE_FN_SLT), 5'd10, sltHi);
    writeRow(10, rType(5'd0, 5'd2, 5'd11, 5'd4, `CORE_FN_SLL), 5'd11, b << 4);
    writeRow(11, rType(5'd0, 5'd2, 5'd12, 5'd28, `CORE_FN_SRL), 5'd12, base);
    // $zero write shows on the port but row 13 must still read zero
    writeRow(12, rType(5'd1, 5'd2, 5'd0, 5'd0, `CORE_FN_ADD), 5'd0, a + b);
    writeRow(13, rType(5'd0, 5'd1, 5'd13, 5'd0, `CORE_FN_OR), 5'd13, a);
    storeRow(14, iType(`CORE_OP_SW, 5'd0, 5'd3, 16'd20), 7'd20, a + b);
    writeRow(15, iType(`CORE_OP_LW, 5'd0, 5'd14, 16'd20), 5'd14, a + b);
    writeRow(16, iType(`CORE_OP_LW, 5'd0, 5'd15, 16'd100), 5'd15, dmem[100]);
    storeRow(17, iType(`CORE_OP_SW, 5'd12, 5'd2, 16'd3), stAddr[6:0], b);
    writeRow(18, iType(`CORE_OP_LW, 5'd12, 5'd16, 16'd3), 5'd16, b);
    // taken beq skips row 20
    flowRow(19, iType(`CORE_OP_BEQ, 5'd1, 5'd13, 16'd1), 32'd84);
    writeRow(20, rType(5'd1, 5'd1, 5'd17, 5'd0, `CORE_FN_ADD), 5'd17, a + a);
    flowRow(21, iType(`CORE_OP_BEQ, 5'd9, 5'd10, 16'd5), (sltLo == sltHi) ? 32'd108 : 32'd88);
    // jal links pc+8, row 23 is never run
    writeRow(22, jType(`CORE_OP_JAL, 32'd104), 5'd31, 32'd96);
    progTable[22].nextPc = 32'd104;
    writeRow(23, rType(5'd1, 5'd2, 5'd20, 5'd0, `CORE_FN_OR), 5'd20, a | b);
    flowRow(24, jType(`CORE_OP_J, 32'd112), 32'd112);
    writeRow(25, rType(5'd2, 5'd2, 5'd21, 5'd0, `CORE_FN_ADD), 5'd21, b + b);
    writeRow(26, rType(5'd31, 5'd0, 5'd18, 5'd0, `CORE_FN_OR), 5'd18, 32'd96);
    flowRow(27, rType(5'd31, 5'd0, 5'd0, 5'd0, `CORE_FN_JR), 32'd96);
    writeRow(28, rType(5'd3, 5'd4, 5'd19, 5'd0, `CORE_FN_ADD), 5'd19, (a + b) + (a - b));
  endtask

  task automatic reportCounts;
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
  endtask

  // ====================
  // stimulus
  // ====================

  initial begin
    instr = idleInstr;
    void'($urandom(32'hdeab_393f));
    for (int i = 0; i < (1 << `CORE_DMEM_AW); i++) begin
      dmem[i] = $urandom;
    end
    buildProgram();
    wait (rst === 1'b1);
    // rst rises on a falling edge, so the first row goes out right away
    while ((instAddr >> 2) < numRows) begin
      instr = progTable[instAddr >> 2].instr;
      @(negedge clk);
    end
    instr = idleInstr;
    // one more edge so the final pc is compared
    @(negedge clk);
    reportCounts();
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeoutNs);
    $display("TIMEOUT: program never finished, pc stuck near %h", instAddr);
    reportCounts();
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/mipsPkg.sv
design/instFetch.sv
design/instDecode.sv
design/regFile.sv
design/execUnit.sv
design/singleCycleMips.sv
tb/tbClock.sv
tb/coreChecker.sv
tb/tbTop.sv

// ==== Bender.yml ====
package:
  name: single_cycle_mips

sources:
  - include_dirs:
      - design
    files:
      - design/mipsPkg.sv
      - design/instFetch.sv
      - design/instDecode.sv
      - design/regFile.sv
      - design/execUnit.sv
      - design/singleCycleMips.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tbClock.sv
      - tb/coreChecker.sv
      - tb/tbTop.sv
